//--- list.f
+incdir+verilog
+incdir+verification
verilog/ec_pkg.sv
verilog/ec_symbol_decode.sv
verilog/ec_interval_update.sv
verilog/ec_renormalize.sv
verilog/arithmetic_encoder.sv
verification/tb_arithmetic_encoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_arithmetic_encoder
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/ec_model.svh
`ifndef EC_MODEL_SVH
`define EC_MODEL_SVH

// Reference coder that advances one symbol at a time by the encoding rules.
int unsigned model_range;
logic [31:0] model_low;
int          model_cnt;
logic [15:0] model_words[$];  // Pre-carry words not yet seen on emit.

task automatic model_reset();
    model_range = `EC_RANGE_INIT;
    model_low   = '0;
    model_cnt   = `EC_CNT_INIT;
    model_words.delete();
endtask

// Halved product of the top byte of the range and a bound reduced to 10 bits.
function automatic int unsigned scaled_product(input int unsigned r, input int unsigned f);
    return ((r >> 8) * (f >> 6)) >> 1;
endfunction

function automatic ec_state_t model_state();
    ec_state_t st;
    st.range = 16'(model_range);
    st.low   = model_low;
    st.cnt   = model_cnt;
    return st;
endfunction

task automatic model_encode(input int unsigned fl, input int unsigned fh,
                            input int unsigned sym, input int unsigned nsyms,
                            output int words);
    int unsigned u;
    int unsigned v;
    int unsigned rng;
    int          d;
    int          c;
    int          s;
    u = scaled_product(model_range, fl) + `EC_MIN_PROB * (nsyms - sym);
    v = scaled_product(model_range, fh) + `EC_MIN_PROB * (nsyms - 1 - sym);
    if (fl < 32768) begin
        model_low = model_low + (model_range - u);
        rng       = u - v;
    end else begin
        rng = model_range - v;  // Top symbol keeps low.
    end
    d = 0;
    while (rng < 32768 && d < 16) begin
        rng = rng << 1;
        d++;
    end
    c     = model_cnt;
    s     = c + d;
    words = 0;
    if (s >= 0) begin
        c = c + 16;
        if (s >= 8) begin
            model_words.push_back(16'(model_low >> c));
            model_low = model_low & ((32'd1 << c) - 32'd1);
            c         = c - 8;
            words++;
        end
        model_words.push_back(16'(model_low >> c));
        model_low = model_low & ((32'd1 << c) - 32'd1);
        s         = c + d - 24;
        words++;
    end
    model_low   = model_low << d;
    model_range = rng;
    model_cnt   = s;
endtask

`endif

//--- verification/tb_arithmetic_encoder.sv
`default_nettype none
`include "ec_params.svh"

module tb_arithmetic_encoder;
    timeunit 1ns;
    timeprecision 100ps;
    import ec_pkg::*;

    logic           general_clk;
    logic           reset;
    logic           symbol_valid;
    ec_symbol_req_t symbol_req;
    ec_state_t      state;
    ec_emit_t       emit;

    int        errors;
    int        timeouts;
    int        seed;
    ec_state_t exp_next;    // State after the symbol issued last.
    ec_state_t exp_now;     // State the DUT shows at this check.
    int        words_next;
    int        words_now;

    `include "ec_model.svh"

    arithmetic_encoder u_dut (
        .general_clk  (general_clk),
        .reset        (reset),
        .symbol_valid (symbol_valid),
        .symbol_req   (symbol_req),
        .state        (state),
        .emit         (emit)
    );

    initial begin
        general_clk = 1'b0;
        forever #20 general_clk = ~general_clk;
    end

    task automatic check_value(input string what, input longint got, input longint expected);
        if (got != expected) begin
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
            errors++;
        end
    endtask

    function automatic int unsigned random_below(input int unsigned limit);
        int unsigned value;
        value = $random(seed);
        return value % limit;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // One clock. The outputs seen now belong to the symbol issued two cycles ago.
    task automatic run_cycle(input logic valid, input int unsigned fl, input int unsigned fh,
                             input int unsigned sym, input int unsigned nsyms);
        int          produced;
        logic [15:0] word;
        check_value("range", longint'(state.range), longint'(exp_now.range));
        check_value("low", longint'(state.low), longint'(exp_now.low));
        check_value("cnt", longint'(state.cnt), longint'(exp_now.cnt));
        check_value("emit count", longint'(emit.count), longint'(words_now));
        for (int n = 0; n < int'(emit.count); n++) begin
            if (model_words.size() == 0) begin
                $display("Error at %0d ns: DUT emitted a word the model did not expect.", $time);
                errors++;
            end else begin
                word = model_words.pop_front();
                check_value("word", longint'(n == 0 ? emit.word0 : emit.word1), longint'(word));
            end
        end
        exp_now   = exp_next;
        words_now = words_next;
        produced  = 0;
        symbol_valid      = valid;
        symbol_req.fl     = 16'(fl);
        symbol_req.fh     = 16'(fh);
        symbol_req.symbol = 4'(sym);
        symbol_req.nsyms  = 5'(nsyms);
        if (valid) begin
            model_encode(fl, fh, sym, nsyms, produced);
        end
        exp_next   = model_state();
        words_next = produced;
        @(posedge general_clk);
        #2;
    endtask

    task automatic idle_cycle();
        run_cycle(1'b0, 0, 0, 0, 0);
    endtask

    task automatic apply_reset();
        symbol_valid = 1'b0;
        reset        = 1'b1;
        repeat (3) @(posedge general_clk);
        #2;
        reset = 1'b0;
        model_reset();
        exp_now    = model_state();
        exp_next   = model_state();
        words_now  = 0;
        words_next = 0;
    endtask

    // Draws an alphabet with a strictly falling inverted CDF and issues one of its symbols.
    task automatic random_symbol();
        int unsigned cdf[17];
        int unsigned nsyms;
        int unsigned sym;
        nsyms  = 2 + random_below(15);
        sym    = random_below(nsyms);
        cdf[0] = 32768;
        for (int i = 1; i < nsyms; i++) begin
            cdf[i] = cdf[i-1] - 1 - random_below(cdf[i-1] / (nsyms + 1 - i));
        end
        cdf[nsyms] = 0;
        run_cycle(1'b1, cdf[sym], cdf[sym+1], sym, nsyms);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    // Reset values hold while idle.
    task automatic reset_values_hold();
        repeat (4) idle_cycle();
    endtask

    // The top symbol of an alphabet leaves low where reset put it.
    task automatic top_symbol();
        run_cycle(1'b1, 32768, 20000, 0, 4);
        repeat (2) idle_cycle();
        check_value("low after top symbol", longint'(state.low), 0);
    endtask

    task automatic middle_symbol();
        run_cycle(1'b1, 16384, 8192, 2, 4);
        repeat (4) idle_cycle();  // The state holds while no symbol arrives.
    endtask

    task automatic random_stream(input int length);
        repeat (length) random_symbol();
        repeat (2) idle_cycle();
    endtask

    // Narrow intervals push the range far down, so one symbol can release two words.
    task automatic improbable_symbols();
        int cycles;
        int doubles;
        cycles  = 0;
        doubles = 0;
        while (doubles < 3 && cycles < 40) begin
            run_cycle(1'b1, 2000 + 8 * cycles, 1999 + 8 * cycles, 5, 16);
            if (emit.count == 2'd2) begin
                doubles++;
            end
            cycles++;
        end
        if (doubles < 3) begin
            $display("Timed out waiting for symbols that emit two words at once.");
            timeouts++;
        end
        repeat (2) idle_cycle();
    endtask

    // Reset lands with symbols still in flight and a fresh stream follows.
    task automatic reset_mid_stream();
        repeat (5) random_symbol();
        apply_reset();
        random_stream(30);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        errors       = 0;
        timeouts     = 0;
        seed         = 32'habffccbb;
        reset        = 1'b1;
        symbol_valid = 1'b0;
        symbol_req   = '0;
        apply_reset();
        reset_values_hold();
        top_symbol();
        middle_symbol();
        random_stream(200);
        improbable_symbols();
        reset_mid_stream();
        check_value("words left in model", longint'(model_words.size()), 0);
        $display("Checks done with %0d value errors and %0d timeouts.", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/arithmetic_encoder.sv
`default_nettype none

module arithmetic_encoder (
    input  logic                   general_clk,
    input  logic                   reset,
    input  logic                   symbol_valid,
    input  ec_pkg::ec_symbol_req_t symbol_req,
    output ec_pkg::ec_state_t      state,
    output ec_pkg::ec_emit_t       emit
);
    import ec_pkg::*;

    logic         scaled_valid;
    ec_scaled_t   scaled;
    ec_interval_t interval;

    //////////////////////////////////////////////////
    // Decode stage with one register
    //////////////////////////////////////////////////

    ec_symbol_decode u_decode (
        .general_clk  (general_clk),
        .reset        (reset),
        .symbol_valid (symbol_valid),
        .symbol_req   (symbol_req),
        .scaled_valid (scaled_valid),
        .scaled       (scaled)
    );

    // Execute reads the live state, so back-to-back symbols chain.
    ec_interval_update u_execute (
        .scaled   (scaled),
        .state    (state),
        .interval (interval)
    );

    ec_renormalize u_result (
        .general_clk  (general_clk),
        .reset        (reset),
        .scaled_valid (scaled_valid),
        .interval     (interval),
        .state        (state),
        .emit         (emit)
    );

endmodule

`default_nettype wire

//--- verilog/ec_renormalize.sv
`default_nettype none
`include "ec_params.svh"

module ec_renormalize (
    input  logic                 general_clk,
    input  logic                 reset,
    input  logic                 scaled_valid,
    input  ec_pkg::ec_interval_t interval,
    output ec_pkg::ec_state_t    state,
    output ec_pkg::ec_emit_t     emit
);
    import ec_pkg::*;

    ec_state_t  state_q;
    ec_state_t  state_d;
    logic [4:0] lz;         // Leading zeros of the new range.
    ec_count_t  zeros;
    ec_count_t  c;
    ec_count_t  s;
    ec_window_t low;
    ec_word_t   word_last;
    logic [1:0] count_d;
    ec_word_t   word0_d;
    ec_word_t   word1_d;
    logic [1:0] emit_count;
    ec_word_t   emit_word0;
    ec_word_t   emit_word1;

    function automatic logic [4:0] lead_zeros(input ec_range_t value);
        logic [4:0] count;
        count = 5'd16;
        for (int i = 0; i < $bits(ec_range_t); i++) begin
            if (value[i]) begin
                count = 5'(15 - i);  // The highest set bit wins.
            end
        end
        return count;
    endfunction

    function automatic ec_window_t low_mask(input logic [4:0] bits);
        return (ec_window_t'(1) << bits) - ec_window_t'(1);
    endfunction

    //////////////////////////////////////////////////
    // Normalization and word extraction
    //////////////////////////////////////////////////

    always_comb begin
        lz        = lead_zeros(interval.range);
        zeros     = ec_count_t'({27'd0, lz});
        c         = state_q.cnt;
        s         = c + zeros;
        low       = interval.low;
        word_last = '0;
        count_d   = 2'd0;
        word0_d   = '0;
        word1_d   = '0;

        // A non-negative count means at least one full word sits above the window.
        if (s >= 0) begin
            c = c + 16;
            if (s >= 8) begin
                word0_d = ec_word_t'(low >> c[4:0]);
                low     = low & low_mask(c[4:0]);
                c       = c - 8;
                count_d = 2'd1;
            end
            word_last = ec_word_t'(low >> c[4:0]);
            low       = low & low_mask(c[4:0]);
            s         = c + zeros - 24;
            if (count_d == 2'd1) begin
                word1_d = word_last;
            end else begin
                word0_d = word_last;
            end
            count_d = count_d + 2'd1;
        end

        state_d.range = interval.range << lz;
        state_d.low   = low << lz;  // Bits shifted past the window are gone.
        state_d.cnt   = s;
    end

    //////////////////////////////////////////////////
    // State and emission registers
    //////////////////////////////////////////////////

    always_ff @(posedge general_clk) begin
        if (reset) begin
            state_q.range <= ec_range_t'(`EC_RANGE_INIT);
            state_q.low   <= '0;
            state_q.cnt   <= ec_count_t'(`EC_CNT_INIT);
            emit_count    <= 2'd0;
        end else if (scaled_valid) begin
            state_q    <= state_d;
            emit_count <= count_d;
        end else begin
            emit_count <= 2'd0;  // Words are shown for one cycle only.
        end
    end

    always_ff @(posedge general_clk) begin
        if (scaled_valid) begin
            emit_word0 <= word0_d;
            emit_word1 <= word1_d;
        end
    end

    assign state       = state_q;
    assign emit.count  = emit_count;
    assign emit.word0  = emit_word0;
    assign emit.word1  = emit_word1;

    // An empty interval means the decode offsets or the CDF were inconsistent.
    a_range_nonzero: assert property (
        @(posedge general_clk) disable iff (reset)
        scaled_valid |-> (interval.range != '0))
        else $error("Interval update produced an empty range.");

    a_range_normalized: assert property (
        @(posedge general_clk) disable iff (reset)
        state_q.range[15])
        else $error("Stored range 0x%04h lost its top bit.", state_q.range);

endmodule

`default_nettype wire

//--- verilog/ec_interval_update.sv
`default_nettype none

module ec_interval_update (
    input  ec_pkg::ec_scaled_t   scaled,
    input  ec_pkg::ec_state_t    state,
    output ec_pkg::ec_interval_t interval
);
    import ec_pkg::*;

    logic [7:0]  range_hi;  // Top byte of the current range.
    logic [17:0] prod_fl;
    logic [17:0] prod_fh;
    ec_range_t   u;
    ec_range_t   v;

    //////////////////////////////////////////////////
    // Range by probability products
    //////////////////////////////////////////////////

    // Only the top 8 bits of the range take part in the multiply.
    assign range_hi = state.range[15:8];

    assign prod_fl = range_hi * scaled.fl_q[9:0];
    assign prod_fh = range_hi * scaled.fh_q[9:0];

    // The products drop one more bit, then take the reserve of the symbols above.
    assign u = prod_fl[16:1] + scaled.u_off;
    assign v = prod_fh[16:1] + scaled.v_off;

    //////////////////////////////////////////////////
    // New interval
    //////////////////////////////////////////////////

    always_comb begin
        if (scaled.has_lower) begin
            // The part of the range above u belongs to lower-indexed symbols.
            interval.range = u - v;
            interval.low   = state.low + ec_window_t'(state.range - u);
        end else begin
            interval.range = state.range - v;  // Low is untouched.
            interval.low   = state.low;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ec_symbol_decode.sv
`default_nettype none
`include "ec_params.svh"

module ec_symbol_decode (
    input  logic                   general_clk,
    input  logic                   reset,
    input  logic                   symbol_valid,
    input  ec_pkg::ec_symbol_req_t symbol_req,
    output logic                   scaled_valid,
    output ec_pkg::ec_scaled_t     scaled
);
    import ec_pkg::*;

    logic [5:0] remain_u;  // Symbols from symbol-1 to the top of the alphabet.
    logic [5:0] remain_v;  // Symbols above the current one.
    ec_scaled_t scaled_d;

    //////////////////////////////////////////////////
    // Scaling and reserve offsets
    //////////////////////////////////////////////////

    always_comb begin
        remain_u = {1'b0, symbol_req.nsyms} - {2'b00, symbol_req.symbol};
        remain_v = remain_u - 6'd1;

        scaled_d.fl_q  = symbol_req.fl >> `EC_PROB_SHIFT;
        scaled_d.fh_q  = symbol_req.fh >> `EC_PROB_SHIFT;
        scaled_d.u_off = ec_range_t'(remain_u * `EC_MIN_PROB);
        scaled_d.v_off = ec_range_t'(remain_v * `EC_MIN_PROB);

        // A bound of exactly 32768 means the symbol starts at the top of the range.
        scaled_d.has_lower = (symbol_req.fl < ec_prob_t'(1 << `EC_PROB_BITS));
    end

    always_ff @(posedge general_clk) begin
        if (reset) begin
            scaled_valid <= 1'b0;
        end else begin
            scaled_valid <= symbol_valid;
        end
    end

    always_ff @(posedge general_clk) begin
        if (symbol_valid) begin
            scaled <= scaled_d;  // Held between symbols.
        end
    end

    //////////////////////////////////////////////////
    // Request contract
    //////////////////////////////////////////////////

    a_nsyms_range: assert property (
        @(posedge general_clk) disable iff (reset)
        symbol_valid |-> (symbol_req.nsyms >= 2) &&
                         (symbol_req.nsyms <= `EC_MAX_SYMBOLS))
        else $error("Alphabet size %0d is outside 2..16.", symbol_req.nsyms);

    a_symbol_in_alphabet: assert property (
        @(posedge general_clk) disable iff (reset)
        symbol_valid |-> ({1'b0, symbol_req.symbol} < symbol_req.nsyms))
        else $error("Symbol %0d is not below nsyms.", symbol_req.symbol);

    // The CDF is inverted, so the bound at the symbol lies below the bound before it.
    a_bounds_ordered: assert property (
        @(posedge general_clk) disable iff (reset)
        symbol_valid |-> (symbol_req.fh < symbol_req.fl))
        else $error("fh %0d is not below fl %0d.", symbol_req.fh, symbol_req.fl);

endmodule

`default_nettype wire

//--- verilog/ec_pkg.sv
`default_nettype none
`include "ec_params.svh"

package ec_pkg;

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    typedef logic [`EC_PROB_BITS:0] ec_prob_t;     // One bit above Q15 so 32768 fits.
    typedef logic [`EC_RANGE_BITS-1:0] ec_range_t;
    typedef logic [`EC_WINDOW_BITS-1:0] ec_window_t;
    typedef logic signed [31:0] ec_count_t;        // Negative while bits are still pending.
    typedef logic [$clog2(`EC_MAX_SYMBOLS)-1:0] ec_symbol_t;
    typedef logic [$clog2(`EC_MAX_SYMBOLS):0] ec_nsyms_t;
    typedef logic [15:0] ec_word_t;

    //////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////

    // One symbol to encode, as presented at the top.
    typedef struct packed {
        ec_prob_t   fl;
        ec_prob_t   fh;
        ec_symbol_t symbol;
        ec_nsyms_t  nsyms;
    } ec_symbol_req_t;

    // Decode output. The bounds are already shifted down to 10 bits.
    typedef struct packed {
        ec_prob_t  fl_q;
        ec_prob_t  fh_q;
        ec_range_t u_off;      // Reserve added to the lower product.
        ec_range_t v_off;      // Reserve added to the upper product.
        logic      has_lower;
    } ec_scaled_t;

    // New interval before normalization.
    typedef struct packed {
        ec_range_t  range;
        ec_window_t low;
    } ec_interval_t;

    typedef struct packed {
        ec_range_t  range;
        ec_window_t low;
        ec_count_t  cnt;
    } ec_state_t;

    // Pre-carry words of one symbol, in the order they were produced.
    typedef struct packed {
        logic [1:0] count;
        ec_word_t   word0;
        ec_word_t   word1;
    } ec_emit_t;

endpackage

`default_nettype wire

//--- verilog/ec_params.svh
`ifndef EC_PARAMS_SVH
`define EC_PARAMS_SVH

//////////////////////////////////////////////////
// Probability model
//////////////////////////////////////////////////

// Precision of the inverted CDF values (Q15).
`define EC_PROB_BITS 15

// Bits dropped from a CDF bound before it meets the range.
`define EC_PROB_SHIFT 6

// Probability kept in reserve for every remaining symbol.
`define EC_MIN_PROB 4

// Largest alphabet the coder accepts.
`define EC_MAX_SYMBOLS 16

//////////////////////////////////////////////////
// Coder state
//////////////////////////////////////////////////

`define EC_RANGE_BITS 16   // Width of the range register.
`define EC_WINDOW_BITS 32  // Width of the low window.

// Values loaded by reset.
`define EC_RANGE_INIT 32768
`define EC_CNT_INIT (-9)

`endif
